// File: project.f
src/periph_pkg.sv
src/bus_bridge.sv
src/input_debounce.sv
src/gpio_regs.sv
src/interval_timer.sv
src/periph_core.sv
tb/periph_core_assertions.sv
tb/tb_periph_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the peripheral core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module tb_periph_core -o sim_periph_core > build.log 2>&1 \
   && ./obj_dir/sim_periph_core > sim.log 2>&1
cat build.log sim.log 2>/dev/null
# the log decides the result
grep -q "Simulation completed successfully" sim.log && echo "run passed" \
   || { echo "run failed"; exit 1; }

// File: src/bus_bridge.sv
/* host to peripheral bridge */

`timescale 1ns/1ps
`default_nettype none

module bus_bridge (
   input  wire                    clk,
   input  wire                    i_arst_n,
   input  wire                    i_req_valid,
   output logic                   o_req_ready,
   input  periph_pkg::bus_req_t    i_req,
   output logic                   o_rsp_valid,
   output periph_pkg::bus_rsp_t    o_rsp,
   input  wire                    i_rsp_ready,
   output periph_pkg::periph_req_t o_gpio_req,
   input  periph_pkg::periph_rsp_t i_gpio_rsp,
   output periph_pkg::periph_req_t o_tmr_req,
   input  periph_pkg::periph_rsp_t i_tmr_rsp
);

   import periph_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_WAIT_ACK, S_RESPOND} state_t;

   state_t               state_q;
   logic [PAGE_W-1:0]    req_page;
   logic [PAGE_W-1:0]    page_q;
   logic                 we_q;
   logic [REG_IDX_W-1:0] idx_q;
   logic [DATA_W-1:0]    wdata_q;
   logic                 gpio_stb_q;
   logic                 tmr_stb_q;
   logic                 req_fire;
   logic                 sel_mapped;
   logic                 rsp_take;
   periph_rsp_t          sel_rsp;
   bus_rsp_t             rsp_q;

   // one access at a time, ready only when idle
   assign o_req_ready = (state_q == S_IDLE);
   assign o_rsp_valid = (state_q == S_RESPOND);
   assign o_rsp       = rsp_q;
   assign req_fire    = i_req_valid & o_req_ready;
   assign req_page    = i_req.addr[ADDR_W-1:PAGE_LSB];

   // answer of the page picked at accept
   always_comb begin
      sel_mapped = 1'b1;
      case (page_q)
         PAGE_GPIO:  sel_rsp = i_gpio_rsp;
         PAGE_TIMER: sel_rsp = i_tmr_rsp;
         default: begin
            // unmapped, rdata reads zero
            sel_rsp    = '0;
            sel_mapped = 1'b0;
         end
      endcase
   end

   assign rsp_take = (state_q == S_WAIT_ACK) & (sel_rsp.ack | ~sel_mapped);

   // ********************
   // control FSM
   // ********************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q    <= S_IDLE;
         gpio_stb_q <= 1'b0;
         tmr_stb_q  <= 1'b0;
      end else begin
         // strobe lives one cycle only
         gpio_stb_q <= 1'b0;
         tmr_stb_q  <= 1'b0;
         case (state_q)
            S_IDLE: begin
               if (req_fire) begin
                  gpio_stb_q <= (req_page == PAGE_GPIO);
                  tmr_stb_q  <= (req_page == PAGE_TIMER);
                  state_q    <= S_ACCESS;
               end
            end
            // peripheral registers its ack here
            S_ACCESS:   state_q <= S_WAIT_ACK;
            S_WAIT_ACK: if (rsp_take) state_q <= S_RESPOND;
            // held until the host takes it
            S_RESPOND:  if (i_rsp_ready) state_q <= S_IDLE;
            default:    state_q <= S_IDLE;
         endcase
      end
   end

   // request and response payload
   always_ff @(posedge clk) begin
      if (req_fire) begin
         page_q  <= req_page;
         we_q    <= i_req.write;
         idx_q   <= i_req.addr[PAGE_LSB-1 -: REG_IDX_W];
         wdata_q <= i_req.wdata;
      end
      if (rsp_take) begin
         rsp_q.rdata <= sel_rsp.rdata;
         rsp_q.err   <= ~sel_mapped;
      end
   end

   assign o_gpio_req = '{stb: gpio_stb_q, we: we_q, reg_idx: idx_q, wdata: wdata_q};
   assign o_tmr_req  = '{stb: tmr_stb_q, we: we_q, reg_idx: idx_q, wdata: wdata_q};

endmodule

`default_nettype wire

// File: src/gpio_regs.sv
/* gpio register block */

`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
   input  wire                           clk,
   input  wire                           i_arst_n,
   input  periph_pkg::periph_req_t        i_req,
   output periph_pkg::periph_rsp_t        o_rsp,
   input  wire  [periph_pkg::GPIO_W-1:0]  i_switch_db,
   output logic [periph_pkg::GPIO_W-1:0]  o_gpio_out,
   output logic [periph_pkg::GPIO_W-1:0]  o_gpio_oe
);

   import periph_pkg::*;

   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;
   logic [DATA_W-1:0] rd_val;
   logic              wr_en;

   assign wr_en = i_req.stb & i_req.we;

   // read mux, zero extended
   always_comb begin
      case (i_req.reg_idx)
         GPIO_REG_OUT: rd_val = DATA_W'(o_gpio_out);
         GPIO_REG_OE:  rd_val = DATA_W'(o_gpio_oe);
         GPIO_REG_IN:  rd_val = DATA_W'(i_switch_db);
         default:      rd_val = '0;
      endcase
   end

   // ********************
   // registers and ack
   // ********************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         ack_q      <= 1'b0;
      end else begin
         // one cycle ack per strobe
         ack_q <= i_req.stb;
         if (wr_en && i_req.reg_idx == GPIO_REG_OUT) begin
            o_gpio_out <= i_req.wdata[GPIO_W-1:0];
         end
         if (wr_en && i_req.reg_idx == GPIO_REG_OE) begin
            o_gpio_oe <= i_req.wdata[GPIO_W-1:0];
         end
      end
   end

   // read data taken with the strobe
   always_ff @(posedge clk) begin
      if (i_req.stb) rdata_q <= rd_val;
   end

   assign o_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: src/input_debounce.sv
/* switch debouncer */

`timescale 1ns/1ps
`default_nettype none

module input_debounce (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire  [periph_pkg::GPIO_W-1:0] i_raw,
   output logic [periph_pkg::GPIO_W-1:0] o_stable
);

   import periph_pkg::*;

   logic [GPIO_W-1:0]         sync1_q;
   logic [GPIO_W-1:0]         sync2_q;
   logic [GPIO_W-1:0]         prev_q;
   logic [DEBOUNCE_CNT_W-1:0] cnt_q;
   logic                      changed;

   // any bit moved since last sample
   assign changed = (sync2_q != prev_q);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync1_q  <= '0;
         sync2_q  <= '0;
         prev_q   <= '0;
         cnt_q    <= '0;
         o_stable <= '0;
      end else begin
         // two flop synchronizer
         sync1_q <= i_raw;
         sync2_q <= sync1_q;
         prev_q  <= sync2_q;

         // restart on change, saturate at the limit
         if (changed) begin
            cnt_q <= '0;
         end else if (cnt_q != DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES)) begin
            cnt_q <= cnt_q + 1'b1;
         end

         // quiet long enough
         if (cnt_q == DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES)) begin
            o_stable <= prev_q;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/interval_timer.sv
/* interval timer */

`timescale 1ns/1ps
`default_nettype none

module interval_timer (
   input  wire                    clk,
   input  wire                    i_arst_n,
   input  periph_pkg::periph_req_t i_req,
   output periph_pkg::periph_rsp_t o_rsp,
   output logic                   o_irq
);

   import periph_pkg::*;

   logic              enable_q;
   logic              irq_en_q;
   logic              pending_q;
   logic [DATA_W-1:0] cmp_q;
   logic [DATA_W-1:0] cnt_q;
   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;
   logic              ctrl_wr;
   logic              cmp_wr;
   logic              match;
   tmr_word_u         wr_word;
   tmr_word_u         rd_word;

   // write word decoded through the union
   assign wr_word.raw = i_req.wdata;
   assign ctrl_wr     = i_req.stb & i_req.we & (i_req.reg_idx == TMR_REG_CTRL);
   assign cmp_wr      = i_req.stb & i_req.we & (i_req.reg_idx == TMR_REG_CMP);
   assign match       = enable_q & (cnt_q == cmp_q);

   // read value, CTRL built as control view
   always_comb begin
      rd_word.raw = '0;
      case (i_req.reg_idx)
         TMR_REG_CTRL: begin
            rd_word.ctrl.enable  = enable_q;
            rd_word.ctrl.irq_en  = irq_en_q;
            rd_word.ctrl.pending = pending_q;
         end
         TMR_REG_CMP: rd_word.raw = cmp_q;
         TMR_REG_CNT: rd_word.raw = cnt_q;
         default:     rd_word.raw = '0;
      endcase
   end

   // ********************
   // count and pending
   // ********************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         enable_q  <= 1'b0;
         irq_en_q  <= 1'b0;
         pending_q <= 1'b0;
         cmp_q     <= '0;
         cnt_q     <= '0;
         o_irq     <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         ack_q <= i_req.stb;
         o_irq <= pending_q & irq_en_q;
         // wrap to zero on compare
         if (match) begin
            cnt_q     <= '0;
            pending_q <= 1'b1;
         end else if (enable_q) begin
            cnt_q <= cnt_q + 1'b1;
         end
         if (cmp_wr) cmp_q <= wr_word.raw;
         if (ctrl_wr) begin
            enable_q <= wr_word.ctrl.enable;
            irq_en_q <= wr_word.ctrl.irq_en;
            // software clear beats a same-cycle match
            if (wr_word.ctrl.clear_pending) pending_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_req.stb) rdata_q <= rd_word.raw;
   end

   assign o_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: src/periph_core.sv
/* peripheral subsystem top */

`timescale 1ns/1ps
`default_nettype none

module periph_core (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire                          i_req_valid,
   output logic                         o_req_ready,
   input  periph_pkg::bus_req_t          i_req,
   output logic                         o_rsp_valid,
   output periph_pkg::bus_rsp_t          o_rsp,
   input  wire                          i_rsp_ready,
   input  wire  [periph_pkg::GPIO_W-1:0] i_switch,
   output logic [periph_pkg::GPIO_W-1:0] o_gpio_out,
   output logic [periph_pkg::GPIO_W-1:0] o_gpio_oe,
   output logic                         o_irq
);

   import periph_pkg::*;

   // per page strobes and answers
   periph_req_t       gpio_req;
   periph_rsp_t       gpio_rsp;
   periph_req_t       tmr_req;
   periph_rsp_t       tmr_rsp;
   // debounced switches
   logic [GPIO_W-1:0] switch_db;

   bus_bridge bus_bridge_inst (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_req_valid (i_req_valid),
      .o_req_ready (o_req_ready),
      .i_req       (i_req),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp),
      .i_rsp_ready (i_rsp_ready),
      .o_gpio_req  (gpio_req),
      .i_gpio_rsp  (gpio_rsp),
      .o_tmr_req   (tmr_req),
      .i_tmr_rsp   (tmr_rsp)
   );

   input_debounce input_debounce_inst (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_raw    (i_switch),
      .o_stable (switch_db)
   );

   gpio_regs gpio_regs_inst (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_req       (gpio_req),
      .o_rsp       (gpio_rsp),
      .i_switch_db (switch_db),
      .o_gpio_out  (o_gpio_out),
      .o_gpio_oe   (o_gpio_oe)
   );

   interval_timer interval_timer_inst (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_req    (tmr_req),
      .o_rsp    (tmr_rsp),
      .o_irq    (o_irq)
   );

endmodule

`default_nettype wire

// File: src/periph_pkg.sv
/* peripheral subsystem definitions */

`default_nettype none

package periph_pkg;

   // ********************
   // widths
   // ********************

   // host byte address
   localparam int ADDR_W = 8;
   // data word
   localparam int DATA_W = 32;
   // output pins and switch inputs
   localparam int GPIO_W = 16;

   // ********************
   // address map
   // ********************

   // page field sits above the register index
   localparam int PAGE_LSB = 6;
   localparam int PAGE_W   = ADDR_W - PAGE_LSB;
   // register index from addr[5:2]
   localparam int REG_IDX_W = 4;

   // pages 2 and 3 unmapped
   localparam logic [PAGE_W-1:0] PAGE_GPIO  = 2'd0;
   localparam logic [PAGE_W-1:0] PAGE_TIMER = 2'd1;

   // gpio registers
   localparam logic [REG_IDX_W-1:0] GPIO_REG_OUT = 4'd0;
   localparam logic [REG_IDX_W-1:0] GPIO_REG_OE  = 4'd1;
   localparam logic [REG_IDX_W-1:0] GPIO_REG_IN  = 4'd2;

   // timer registers
   localparam logic [REG_IDX_W-1:0] TMR_REG_CTRL = 4'd0;
   localparam logic [REG_IDX_W-1:0] TMR_REG_CMP  = 4'd1;
   localparam logic [REG_IDX_W-1:0] TMR_REG_CNT  = 4'd2;

   // unchanged samples needed before a switch change is taken
   localparam int DEBOUNCE_CYCLES = 8;
   localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);

   // ********************
   // bus types
   // ********************

   // host request, 41 bits
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic              write;
   } bus_req_t;

   // host response, 33 bits
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              err;
   } bus_rsp_t;

   // strobe to one peripheral, 38 bits
   typedef struct packed {
      logic                 stb;
      logic                 we;
      logic [REG_IDX_W-1:0] reg_idx;
      logic [DATA_W-1:0]    wdata;
   } periph_req_t;

   // peripheral answer, 33 bits
   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] rdata;
   } periph_rsp_t;

   // timer control word
   typedef struct packed {
      logic [DATA_W-5:0] reserved;
      logic              pending;        // read only
      logic              clear_pending;  // write only
      logic              irq_en;
      logic              enable;
   } tmr_ctrl_t;

   // same word seen as control fields or as a count
   typedef union packed {
      tmr_ctrl_t         ctrl;
      logic [DATA_W-1:0] raw;
   } tmr_word_u;

endpackage

`default_nettype wire

// File: tb/periph_core_assertions.sv
/* host handshake and strobe checks */

`timescale 1ns/1ps
`default_nettype none

module periph_core_assertions (
   input wire                     clk,
   input wire                     i_arst_n,
   input wire                     i_req_valid,
   input wire                     i_req_ready,
   input wire                     i_rsp_valid,
   input periph_pkg::bus_rsp_t    i_rsp,
   input wire                     i_rsp_ready,
   input periph_pkg::periph_req_t i_gpio_req,
   input periph_pkg::periph_rsp_t i_gpio_rsp,
   input periph_pkg::periph_req_t i_tmr_req,
   input periph_pkg::periph_rsp_t i_tmr_rsp
);

   // ********************
   // host side
   // ********************

   // held response keeps its value until taken
   rsp_stable_a: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp))
      else $error("response changed before the host took it");

   // busy or answering, ready stays low until the response transfers
   no_accept_a: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_rsp_valid || !i_req_ready) && !(i_rsp_valid && i_rsp_ready) |=> !i_req_ready)
      else $error("request ready high while a response is pending");

   // ********************
   // peripheral side
   // ********************

   // ack exactly one cycle after stb
   gpio_ack_a: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_gpio_rsp.ack == $past(i_gpio_req.stb))
      else $error("gpio ack does not follow its strobe");

   tmr_ack_a: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_tmr_rsp.ack == $past(i_tmr_req.stb))
      else $error("timer ack does not follow its strobe");

   // one page strobed at a time, only right after an accept
   one_stb_a: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_gpio_req.stb || i_tmr_req.stb) |->
         !(i_gpio_req.stb && i_tmr_req.stb) && $past(i_req_valid && i_req_ready))
      else $error("peripheral strobe without a single accepted request");

endmodule

`default_nettype wire

// File: tb/tb_periph_core.sv
/* peripheral core testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_periph_core;

   import periph_pkg::*;

   // longest wait in cycles before giving up
   localparam int MAX_WAIT = 200;

   logic              clk = 1'b0;
   logic              arst_n;
   logic              req_valid;
   logic              req_ready;
   bus_req_t          req;
   logic              rsp_valid;
   bus_rsp_t          rsp;
   logic              rsp_ready;
   logic [GPIO_W-1:0] switch_in;
   logic [GPIO_W-1:0] gpio_out;
   logic [GPIO_W-1:0] gpio_oe;
   logic              irq;
   // lcg state and values expected back from the registers
   logic [31:0]       lcg_state;
   logic [GPIO_W-1:0] exp_out;
   logic [GPIO_W-1:0] exp_oe;
   logic [GPIO_W-1:0] exp_in;

   periph_core periph_core_inst (
      .clk         (clk),
      .i_arst_n    (arst_n),
      .i_req_valid (req_valid),
      .o_req_ready (req_ready),
      .i_req       (req),
      .o_rsp_valid (rsp_valid),
      .o_rsp       (rsp),
      .i_rsp_ready (rsp_ready),
      .i_switch    (switch_in),
      .o_gpio_out  (gpio_out),
      .o_gpio_oe   (gpio_oe),
      .o_irq       (irq)
   );

   bind periph_core periph_core_assertions periph_core_assertions_inst (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_req_valid (i_req_valid),
      .i_req_ready (o_req_ready),
      .i_rsp_valid (o_rsp_valid),
      .i_rsp       (o_rsp),
      .i_rsp_ready (i_rsp_ready),
      .i_gpio_req  (gpio_req),
      .i_gpio_rsp  (gpio_rsp),
      .i_tmr_req   (tmr_req),
      .i_tmr_rsp   (tmr_rsp)
   );

   // 4 ns period
   initial begin
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic bus_req_t make_req(input logic [PAGE_W-1:0] page,
      input logic [REG_IDX_W-1:0] idx, input logic write, input logic [DATA_W-1:0] data);
      bus_req_t r;
      // page, register index, byte offset zero
      r.addr  = {page, idx, 2'b00};
      r.wdata = data;
      r.write = write;
      return r;
   endfunction

   function automatic bus_rsp_t make_rsp(input logic [DATA_W-1:0] data, input logic err);
      bus_rsp_t r;
      r.rdata = data;
      r.err   = err;
      return r;
   endfunction

   // ********************
   // failure and compare
   // ********************
   task automatic fail_now(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
      if (act !== exp) begin
         fail_now($sformatf("Fail %s expected rdata=%h err=%b actual rdata=%h err=%b",
            name, exp.rdata, exp.err, act.rdata, act.err));
      end
   endtask

   task automatic check_vec(input string name, input logic [GPIO_W-1:0] exp,
      input logic [GPIO_W-1:0] act);
      if (act !== exp) begin
         fail_now($sformatf("Fail %s expected %h actual %h", name, exp, act));
      end
   endtask

   // ********************
   // bus access
   // ********************
   task automatic bus_access(input string name, input bus_req_t r, input int stall,
      output bus_rsp_t got);
      int       n;
      bus_rsp_t held;
      @(negedge clk);
      req       = r;
      req_valid = 1'b1;
      n         = 0;
      // transfer on the next rising edge once ready is seen
      while (!req_ready) begin
         @(negedge clk);
         n++;
         if (n > MAX_WAIT) fail_now($sformatf("%s: request was never accepted", name));
      end
      @(negedge clk);
      req_valid = 1'b0;
      n         = 0;
      while (!rsp_valid) begin
         @(negedge clk);
         n++;
         if (n > MAX_WAIT) fail_now($sformatf("%s: no response arrived", name));
      end
      held = rsp;
      // host stalls, response must hold
      for (int i = 0; i < stall; i++) begin
         @(negedge clk);
         if (!rsp_valid) fail_now($sformatf("%s: response valid dropped early", name));
         if (req_ready) fail_now($sformatf("%s: request ready high during stall", name));
         check_rsp({name, " held"}, held, rsp);
      end
      rsp_ready = 1'b1;
      @(negedge clk);
      rsp_ready = 1'b0;
      got       = held;
   endtask

   task automatic write_reg(input string name, input logic [PAGE_W-1:0] page,
      input logic [REG_IDX_W-1:0] idx, input logic [DATA_W-1:0] data);
      bus_rsp_t got;
      bus_access(name, make_req(page, idx, 1'b1, data), 0, got);
      if (got.err) fail_now($sformatf("%s: write answered with an error", name));
   endtask

   task automatic read_reg(input string name, input logic [PAGE_W-1:0] page,
      input logic [REG_IDX_W-1:0] idx, input int stall, output bus_rsp_t got);
      bus_access(name, make_req(page, idx, 1'b0, '0), stall, got);
   endtask

   task automatic read_expect(input string name, input logic [PAGE_W-1:0] page,
      input logic [REG_IDX_W-1:0] idx, input int stall, input logic [DATA_W-1:0] data);
      bus_rsp_t got;
      read_reg(name, page, idx, stall, got);
      check_rsp(name, make_rsp(data, 1'b0), got);
   endtask

   // poll IN until the debounced value shows up
   task automatic wait_switches(input string name, input logic [GPIO_W-1:0] expected);
      bus_rsp_t got;
      int       n;
      n = 0;
      read_reg(name, PAGE_GPIO, GPIO_REG_IN, 0, got);
      while (got.rdata[GPIO_W-1:0] !== expected) begin
         n++;
         if (n > 20) fail_now($sformatf("%s: switches never settled to %h", name, expected));
         read_reg(name, PAGE_GPIO, GPIO_REG_IN, 0, got);
      end
      check_rsp(name, make_rsp(DATA_W'(expected), 1'b0), got);
   endtask

   // ********************
   // directed tests
   // ********************
   task automatic test_reset();
      if (!req_ready) fail_now("reset: request ready is low after reset");
      if (rsp_valid) fail_now("reset: response valid is high after reset");
      if (irq) fail_now("reset: interrupt is high after reset");
      check_vec("reset gpio_out", '0, gpio_out);
      check_vec("reset gpio_oe", '0, gpio_oe);
      read_expect("reset OUT", PAGE_GPIO, GPIO_REG_OUT, 0, '0);
      read_expect("reset OE", PAGE_GPIO, GPIO_REG_OE, 0, '0);
      read_expect("reset CMP", PAGE_TIMER, TMR_REG_CMP, 0, '0);
      read_expect("reset CNT", PAGE_TIMER, TMR_REG_CNT, 0, '0);
   endtask

   task automatic test_gpio();
      logic [DATA_W-1:0] out_word;
      logic [DATA_W-1:0] oe_word;
      out_word = next_rand();
      oe_word  = next_rand();
      // only the low pins are kept
      exp_out  = out_word[GPIO_W-1:0];
      exp_oe   = oe_word[GPIO_W-1:0];
      write_reg("gpio OUT write", PAGE_GPIO, GPIO_REG_OUT, out_word);
      write_reg("gpio OE write", PAGE_GPIO, GPIO_REG_OE, oe_word);
      read_expect("gpio OUT read", PAGE_GPIO, GPIO_REG_OUT, 0, DATA_W'(exp_out));
      read_expect("gpio OE read", PAGE_GPIO, GPIO_REG_OE, 0, DATA_W'(exp_oe));
      check_vec("gpio out pins", exp_out, gpio_out);
      check_vec("gpio oe pins", exp_oe, gpio_oe);
      read_expect("gpio unused 3", PAGE_GPIO, 4'd3, 0, '0);
      read_expect("gpio unused 15", PAGE_GPIO, 4'd15, 0, '0);
   endtask

   task automatic test_debounce();
      logic [DATA_W-1:0] word;
      logic [GPIO_W-1:0] sw_a;
      logic [GPIO_W-1:0] sw_b;
      word = next_rand();
      sw_a = word[31:16];
      sw_b = ~sw_a;
      @(negedge clk);
      switch_in = sw_a;
      wait_switches("debounce settle A", sw_a);
      fork
         begin
            // toggle every cycle, never quiet long enough
            for (int i = 0; i < 40; i++) begin
               @(negedge clk);
               switch_in = i[0] ? sw_b : sw_a;
            end
         end
         begin
            // odd access length, so reads land on both phases
            repeat (4) begin
               read_expect("debounce during bounce", PAGE_GPIO, GPIO_REG_IN, 0,
                  DATA_W'(sw_a));
            end
         end
      join
      @(negedge clk);
      switch_in = sw_a;
      repeat (DEBOUNCE_CYCLES * 3) @(negedge clk);
      read_expect("debounce bounce", PAGE_GPIO, GPIO_REG_IN, 0, DATA_W'(sw_a));
      @(negedge clk);
      switch_in = sw_b;
      wait_switches("debounce settle B", sw_b);
      exp_in = sw_b;
   endtask

   task automatic test_timer();
      logic [DATA_W-1:0] cmp_val;
      bus_rsp_t          got;
      int                n;
      // compare between 4 and 19
      cmp_val = 32'd4 + (next_rand() >> 28);
      write_reg("timer CMP write", PAGE_TIMER, TMR_REG_CMP, cmp_val);
      read_expect("timer CMP read", PAGE_TIMER, TMR_REG_CMP, 0, cmp_val);
      // enable and irq_en
      write_reg("timer start", PAGE_TIMER, TMR_REG_CTRL, 32'h0000_0003);
      n = 0;
      while (!irq) begin
         @(negedge clk);
         n++;
         if (n > MAX_WAIT) fail_now("timer: interrupt was never raised");
      end
      // pending, irq_en and enable all set
      read_expect("timer CTRL pending", PAGE_TIMER, TMR_REG_CTRL, 0, 32'h0000_000B);
      read_reg("timer CNT", PAGE_TIMER, TMR_REG_CNT, 0, got);
      if (got.err) fail_now("timer CNT: read answered with an error");
      if (got.rdata > cmp_val) begin
         fail_now($sformatf("Fail timer CNT expected at most %0d actual %0d",
            cmp_val, got.rdata));
      end
      // clear_pending and irq_en, count stopped
      write_reg("timer clear", PAGE_TIMER, TMR_REG_CTRL, 32'h0000_0006);
      n = 0;
      while (irq) begin
         @(negedge clk);
         n++;
         if (n > MAX_WAIT) fail_now("timer: interrupt stayed high after clear");
      end
      read_expect("timer CTRL cleared", PAGE_TIMER, TMR_REG_CTRL, 0, 32'h0000_0002);
   endtask

   task automatic test_errors();
      bus_rsp_t          got;
      int                stall;
      logic [GPIO_W-1:0] exp_vals [4];
      read_reg("unmapped read", 2'd2, 4'd0, 0, got);
      check_rsp("unmapped read", make_rsp('0, 1'b1), got);
      bus_access("unmapped write", make_req(2'd3, 4'd0, 1'b1, next_rand()), 0, got);
      check_rsp("unmapped write", make_rsp('0, 1'b1), got);
      check_vec("unmapped write pins", exp_out, gpio_out);
      // reads under back-pressure
      exp_vals = '{exp_out, exp_oe, exp_in, 16'h0000};
      for (int i = 0; i < 4; i++) begin
         stall = 1 + int'(next_rand() >> 29);
         read_expect($sformatf("backpressure idx %0d", i), PAGE_GPIO, REG_IDX_W'(i),
            stall, DATA_W'(exp_vals[i]));
      end
   endtask

   initial begin
      arst_n    = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      rsp_ready = 1'b0;
      switch_in = '0;
      lcg_state = 32'ha382;
      exp_out   = '0;
      exp_oe    = '0;
      exp_in    = '0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      test_reset();
      test_gpio();
      test_debounce();
      test_timer();
      test_errors();
      repeat (4) @(negedge clk);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire
